//--- periph_fabric_top.f
periph_fabric_pkg.sv
periph_addr_decoder.sv
periph_regblock.sv
periph_resp_combiner.sv
periph_fabric_top.sv
periph_fabric_chk.sv
tb_periph_fabric.sv

//--- Makefile
# Verilator flow for the peripheral fabric

VERILATOR  ?= verilator
FILELIST   ?= periph_fabric_top.f
TB_TOP     ?= tb_periph_fabric
RTL_TOP    ?= periph_fabric_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# The run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_periph_fabric.sv
// Testbench for the peripheral fabric with a register model and an in-order response check
`timescale 1ns/1ps
`default_nettype none

module tb_periph_fabric;

    import periph_fabric_pkg::*;

    localparam int CLK_HALF       = 50;
    localparam int RESET_CYCLES   = 10;
    localparam int RSP_LATENCY    = 3;          // Strobe to response, in cycles
    localparam logic [DATA_W-1:0] ID_BASE = 32'h0000_00A0;
    localparam int N_ID_REQ       = NUM_RESP;
    localparam int N_RAND_REQ     = 64;
    localparam int N_IRQ_REQ      = 8 * NUM_RESP;
    localparam int N_UNMAP_REQ    = 2 * (8 - NUM_RESP) + 2 * NUM_RESP;
    localparam int N_DIS_REQ      = 8 * NUM_RESP;
    localparam int TOTAL_REQ      = N_ID_REQ + N_RAND_REQ + N_IRQ_REQ + N_UNMAP_REQ + N_DIS_REQ;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_REQ + RESET_CYCLES + 100;

    typedef struct packed {
        logic                err;
        logic [DATA_W-1:0]   rdata;
        logic [NUM_INTR-1:0] irq;   // Vector right after this response
    } exp_rsp_t;

    logic                clk = 1'b0;
    logic                reset_i;
    bus_req_t            req_i;
    logic [NUM_RESP-1:0] resp_disable_i;
    bus_rsp_t            rsp_o;
    logic [NUM_INTR-1:0] irq_o;
    logic                access_blocked_o;

    integer   seed = 20369;
    int       cycle_cnt = 0;
    int       blocked_seen = 0;
    exp_rsp_t exp_q[$];
    string    name_q[$];

    // Register model
    logic [DATA_W-1:0]   mdl_cmd [NUM_RESP];
    logic [DATA_W-1:0]   mdl_scratch [NUM_RESP];
    logic [NUM_RESP-1:0] mdl_err;
    logic [NUM_RESP-1:0] mdl_notif;
    logic [NUM_RESP-1:0] mdl_disable;
    int                  mdl_blocked = 0;

    periph_fabric_top u_periph_fabric_top (
        .clk              ( clk              ),
        .reset_i          ( reset_i          ),
        .req_i            ( req_i            ),
        .resp_disable_i   ( resp_disable_i   ),
        .rsp_o            ( rsp_o            ),
        .irq_o            ( irq_o            ),
        .access_blocked_o ( access_blocked_o )
    );

    always #(CLK_HALF) clk = ~clk;

    // ========================================================================
    // Helpers
    // ========================================================================
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("ERR %s expected 0x%0h actual 0x%0h",
                                        name, expected, actual));
        end
    endtask

    function automatic logic [DATA_W-1:0] next_random();
        next_random = $random(seed);
    endfunction

    // Expected answer of one request, model updated in request order
    function automatic exp_rsp_t predict_response(input logic write, input int sel,
                                                  input logic [REG_IDX_W-1:0] reg_idx,
                                                  input logic [DATA_W-1:0] wdata);
        exp_rsp_t r;
        r.err   = 1'b0;
        r.rdata = '0;
        if (sel >= NUM_RESP) begin
            r.err = 1'b1;                           // Unmapped window
        end else if (mdl_disable[sel]) begin
            r.err = 1'b1;
            mdl_blocked++;
        end else if (write) begin
            case (reg_idx)
                REG_CMD: begin
                    mdl_cmd[sel]   = wdata;
                    mdl_notif[sel] = 1'b1;
                end
                REG_ID:      mdl_err[sel] = 1'b1;  // Read-only word
                REG_SCRATCH: mdl_scratch[sel] = wdata;
                default: begin
                    if (wdata[1]) mdl_err[sel] = 1'b0;
                    if (wdata[0]) mdl_notif[sel] = 1'b0;
                end
            endcase
        end else begin
            case (reg_idx)
                REG_CMD:     r.rdata = mdl_cmd[sel];
                REG_ID:      r.rdata = ID_BASE + DATA_W'(sel);
                REG_SCRATCH: r.rdata = mdl_scratch[sel];
                default:     r.rdata = {{(DATA_W-2){1'b0}}, mdl_err[sel], mdl_notif[sel]};
            endcase
        end
        r.irq = '0;
        for (int i = 0; i < NUM_RESP; i++) begin
            r.irq[2*i+1] = mdl_err[i];
            r.irq[2*i+2] = mdl_notif[i];
        end
        return r;
    endfunction

    task automatic issue(input logic write, input int sel, input logic [REG_IDX_W-1:0] reg_idx,
                         input logic [DATA_W-1:0] wdata, input string name);
        bus_req_t          req;
        logic [DATA_W-1:0] rnd;
        rnd            = next_random();
        req.valid      = 1'b1;
        req.write      = write;
        req.addr.raw   = {SEL_W'(sel), reg_idx, rnd[1:0]};   // Random byte offset
        req.wdata      = wdata;
        @(posedge clk);
        req_i <= req;
        exp_q.push_back(predict_response(write, sel, reg_idx, wdata));
        name_q.push_back(name);
    endtask

    task automatic set_disable(input logic [NUM_RESP-1:0] mask);
        @(posedge clk);
        req_i.valid    <= 1'b0;
        resp_disable_i <= mask;
        mdl_disable     = mask;
    endtask

    // Stop issuing, every outstanding response is due within the fixed latency
    task automatic wait_idle();
        int waited;
        waited = 0;
        @(posedge clk);
        req_i.valid <= 1'b0;
        while (exp_q.size() != 0 && waited < RSP_LATENCY + 2) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            stop_with_failure("responses still outstanding after the response latency");
        end
    endtask

    // ========================================================================
    // Compare and timeout
    // ========================================================================
    always @(negedge clk) begin : compare_responses
        exp_rsp_t expected;
        string    name;
        if (!reset_i) begin
            if (access_blocked_o) begin
                blocked_seen++;
            end
            if (rsp_o.valid) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("a response arrived while no request was outstanding");
                end else begin
                    expected = exp_q.pop_front();
                    name     = name_q.pop_front();
                    check_value({name, " err"}, 64'(expected.err), 64'(rsp_o.err));
                    check_value({name, " rdata"}, 64'(expected.rdata), 64'(rsp_o.rdata));
                    check_value({name, " irq"}, 64'(expected.irq), 64'(irq_o));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_with_failure("timeout, the run did not finish within the cycle limit");
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin : stimulus
        int                sel;
        logic [DATA_W-1:0] rnd;
        reset_i        = 1'b1;
        req_i          = '0;
        resp_disable_i = '0;
        mdl_err        = '0;
        mdl_notif      = '0;
        mdl_disable    = '0;
        for (int i = 0; i < NUM_RESP; i++) begin
            mdl_cmd[i]     = '0;
            mdl_scratch[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;

        // Identity words
        for (int i = 0; i < NUM_RESP; i++) begin
            issue(1'b0, i, REG_ID, '0, "identity read");
        end
        wait_idle();

        // Back to back random traffic on the read/write words
        for (int k = 0; k < N_RAND_REQ; k++) begin
            rnd = next_random();
            sel = rnd[7:0] % NUM_RESP;
            issue(rnd[9], sel, rnd[8] ? REG_SCRATCH : REG_CMD, next_random(), "random access");
        end
        wait_idle();

        // Interrupt flags per responder
        for (int i = 0; i < NUM_RESP; i++) begin
            issue(1'b1, i, REG_STATUS, 32'h3, "irq clear all");
            issue(1'b1, i, REG_CMD, next_random(), "irq cmd write");
            wait_idle();
            check_value("irq notif after cmd write", 64'(1), 64'(irq_o[2*i+2]));
            check_value("irq err after cmd write", 64'(0), 64'(irq_o[2*i+1]));
            issue(1'b1, i, REG_ID, next_random(), "irq id write");
            issue(1'b0, i, REG_STATUS, '0, "irq status both");
            wait_idle();
            check_value("irq err after id write", 64'(1), 64'(irq_o[2*i+1]));
            issue(1'b1, i, REG_STATUS, 32'h1, "irq clear notif");
            issue(1'b0, i, REG_STATUS, '0, "irq status err only");
            wait_idle();
            check_value("irq notif after clear", 64'(0), 64'(irq_o[2*i+2]));
            check_value("irq err kept", 64'(1), 64'(irq_o[2*i+1]));
            issue(1'b1, i, REG_STATUS, 32'h2, "irq clear err");
            issue(1'b0, i, REG_STATUS, '0, "irq status clear");
        end
        wait_idle();

        // Unmapped windows, then show that no block changed
        for (int s = NUM_RESP; s < 8; s++) begin
            rnd = next_random();
            issue(1'b1, s, rnd[1:0], next_random(), "unmapped write");
            issue(1'b0, s, rnd[3:2], '0, "unmapped read");
        end
        for (int i = 0; i < NUM_RESP; i++) begin
            issue(1'b0, i, REG_CMD, '0, "unmapped no change");
            issue(1'b0, i, REG_SCRATCH, '0, "unmapped no change");
        end
        wait_idle();

        // Locked responders
        for (int d = 0; d < NUM_RESP; d++) begin
            set_disable(NUM_RESP'(1 << d));
            issue(1'b1, d, REG_CMD, next_random(), "disabled cmd write");
            issue(1'b1, d, REG_SCRATCH, next_random(), "disabled scratch write");
            issue(1'b1, d, REG_ID, next_random(), "disabled id write");
            issue(1'b0, d, REG_CMD, '0, "disabled cmd read");
            issue(1'b0, (d + 1) % NUM_RESP, REG_CMD, '0, "disable neighbour read");
            set_disable('0);
            issue(1'b0, d, REG_CMD, '0, "restored cmd read");
            issue(1'b0, d, REG_SCRATCH, '0, "restored scratch read");
            issue(1'b0, d, REG_STATUS, '0, "restored status read");
        end
        wait_idle();
        check_value("access blocked count", 64'(mdl_blocked), 64'(blocked_seen));

        if (u_periph_fabric_top.u_periph_fabric_chk.fail_count != 0) begin
            stop_with_failure("an assertion in the bound checker failed");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- periph_fabric_chk.sv
// Concurrent assertions on the peripheral fabric outputs, bound to the top level
`timescale 1ns/1ps
`default_nettype none

module periph_fabric_chk (
    input  logic                                   clk,
    input  logic                                   reset_i,
    input  periph_fabric_pkg::bus_req_t            req_i,
    input  periph_fabric_pkg::bus_rsp_t            rsp_o,
    input  logic [periph_fabric_pkg::NUM_INTR-1:0] irq_o,
    input  logic                                   access_blocked_o
);

    int fail_count = 0;     // Polled by the testbench

    // ========================================================================
    // Response and interrupt properties
    // ========================================================================
    // Two responses in a row need two requests in a row, three cycles earlier
    a_rsp_back_to_back: assert property (@(posedge clk) disable iff (reset_i)
        (rsp_o.valid && $past(rsp_o.valid)) |-> ($past(req_i.valid, 3) && $past(req_i.valid, 4)))
        else begin
            fail_count++;
            $error("rsp_o.valid high on consecutive cycles without back to back requests");
        end

    a_irq_reserved: assert property (@(posedge clk) disable iff (reset_i) !irq_o[0])
        else begin
            fail_count++;
            $error("reserved interrupt bit 0 set");
        end

    a_blocked_err: assert property (@(posedge clk) disable iff (reset_i)
        access_blocked_o |-> ##2 (rsp_o.valid && rsp_o.err))
        else begin
            fail_count++;
            $error("blocked access not answered with an error response");
        end

    a_no_unknown: assert property (@(posedge clk) disable iff (reset_i)
        !$isunknown({rsp_o, irq_o, access_blocked_o}))
        else begin
            fail_count++;
            $error("unknown value on a fabric output");
        end

endmodule

bind periph_fabric_top periph_fabric_chk u_periph_fabric_chk (
    .clk              ( clk              ),
    .reset_i          ( reset_i          ),
    .req_i            ( req_i            ),
    .rsp_o            ( rsp_o            ),
    .irq_o            ( irq_o            ),
    .access_blocked_o ( access_blocked_o )
);

`default_nettype wire

//--- periph_fabric_top.sv
// Peripheral fabric top joining the decoder, the register blocks and the response combiner
`timescale 1ns/1ps
`default_nettype none

module periph_fabric_top (
    input  logic                                   clk,
    input  logic                                   reset_i,
    input  periph_fabric_pkg::bus_req_t            req_i,
    input  logic [periph_fabric_pkg::NUM_RESP-1:0] resp_disable_i,
    output periph_fabric_pkg::bus_rsp_t            rsp_o,
    output logic [periph_fabric_pkg::NUM_INTR-1:0] irq_o,
    output logic                                   access_blocked_o
);

    import periph_fabric_pkg::*;

    blk_req_t                  blk_req;     // Shared by every block
    logic [NUM_RESP-1:0]       blk_sel;
    logic                      dec_err;
    blk_rsp_t [NUM_RESP-1:0]   blk_rsp;
    logic [NUM_RESP-1:0]       err_irq;
    logic [NUM_RESP-1:0]       notif_irq;

    // ========================================================================
    // Decode stage
    // ========================================================================
    periph_addr_decoder u_periph_addr_decoder (
        .clk              ( clk              ),
        .reset_i          ( reset_i          ),
        .req_i            ( req_i            ),
        .resp_disable_i   ( resp_disable_i   ),
        .blk_req_o        ( blk_req          ),
        .blk_sel_o        ( blk_sel          ),
        .dec_err_o        ( dec_err          ),
        .access_blocked_o ( access_blocked_o )
    );

    // ========================================================================
    // Register blocks
    // ========================================================================
    for (genvar i = 0; i < NUM_RESP; i++) begin : g_regblock
        periph_regblock #(
            .INST_ID ( INST_ID_BASE + DATA_W'(i) )
        ) u_periph_regblock (
            .clk         ( clk          ),
            .reset_i     ( reset_i      ),
            .sel_i       ( blk_sel[i]   ),
            .blk_req_i   ( blk_req      ),
            .blk_rsp_o   ( blk_rsp[i]   ),
            .err_irq_o   ( err_irq[i]   ),
            .notif_irq_o ( notif_irq[i] )
        );
    end

    // Response and interrupt merge
    periph_resp_combiner u_periph_resp_combiner (
        .clk         ( clk       ),
        .reset_i     ( reset_i   ),
        .dec_err_i   ( dec_err   ),
        .blk_rsp_i   ( blk_rsp   ),
        .err_irq_i   ( err_irq   ),
        .notif_irq_i ( notif_irq ),
        .rsp_o       ( rsp_o     ),
        .irq_o       ( irq_o     )
    );

endmodule

`default_nettype wire

//--- periph_resp_combiner.sv
// Response combiner merging block read data and decode errors, and building the interrupt vector
`timescale 1ns/1ps
`default_nettype none

module periph_resp_combiner (
    input  logic                                          clk,
    input  logic                                          reset_i,
    input  logic                                          dec_err_i,
    input  periph_fabric_pkg::blk_rsp_t [periph_fabric_pkg::NUM_RESP-1:0] blk_rsp_i,
    input  logic [periph_fabric_pkg::NUM_RESP-1:0]        err_irq_i,
    input  logic [periph_fabric_pkg::NUM_RESP-1:0]        notif_irq_i,
    output periph_fabric_pkg::bus_rsp_t                   rsp_o,
    output logic [periph_fabric_pkg::NUM_INTR-1:0]        irq_o
);

    import periph_fabric_pkg::*;

    logic                dec_err_q;   // Lines the error up with block responses
    logic                blk_any;
    logic [DATA_W-1:0]   rdata_or;
    logic [NUM_INTR-1:0] irq_vec;

    // ========================================================================
    // Merge
    // ========================================================================
    always_comb begin
        blk_any  = 1'b0;
        rdata_or = '0;
        for (int i = 0; i < NUM_RESP; i++) begin
            blk_any  = blk_any | blk_rsp_i[i].valid;
            rdata_or = rdata_or | ({DATA_W{blk_rsp_i[i].valid}} & blk_rsp_i[i].rdata);
        end
    end

    // Vector 0 stays reserved, each responder owns an error and notify pair
    always_comb begin
        irq_vec = '0;
        for (int i = 0; i < NUM_RESP; i++) begin
            irq_vec[2*i+1] = err_irq_i[i];
            irq_vec[2*i+2] = notif_irq_i[i];
        end
    end

    // ========================================================================
    // Output stage
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_err_q <= 1'b0;
            rsp_o     <= '0;
            irq_o     <= '0;
        end else begin
            dec_err_q   <= dec_err_i;
            rsp_o.valid <= blk_any | dec_err_q;
            rsp_o.err   <= dec_err_q;
            rsp_o.rdata <= dec_err_q ? '0 : rdata_or;
            irq_o       <= irq_vec;                     // Same edge as the response
        end
    end

endmodule

`default_nettype wire

//--- periph_regblock.sv
// Peripheral register block with identity, command and scratch words and interrupt status
`timescale 1ns/1ps
`default_nettype none

module periph_regblock #(
    parameter logic [periph_fabric_pkg::DATA_W-1:0] INST_ID = '0
) (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        sel_i,
    input  periph_fabric_pkg::blk_req_t blk_req_i,
    output periph_fabric_pkg::blk_rsp_t blk_rsp_o,
    output logic                        err_irq_o,
    output logic                        notif_irq_o
);

    import periph_fabric_pkg::*;

    logic [DATA_W-1:0] cmd_q;
    logic [DATA_W-1:0] scratch_q;
    logic              err_q;       // Set by a write to the read-only identity word
    logic              notif_q;     // Set by a command write
    logic [DATA_W-1:0] rd_mux;
    logic              wr_en;

    assign wr_en = sel_i && blk_req_i.write;

    // ========================================================================
    // Read mux
    // ========================================================================
    always_comb begin
        rd_mux = '0;
        case (blk_req_i.reg_idx)
            REG_CMD:     rd_mux = cmd_q;
            REG_ID:      rd_mux = INST_ID;
            REG_SCRATCH: rd_mux = scratch_q;
            REG_STATUS:  rd_mux = {{(DATA_W-2){1'b0}}, err_q, notif_q};
            default:     rd_mux = '0;
        endcase
    end

    // ========================================================================
    // Register writes
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cmd_q     <= '0;
            scratch_q <= '0;
            err_q     <= 1'b0;
            notif_q   <= 1'b0;
        end else if (wr_en) begin
            case (blk_req_i.reg_idx)
                REG_CMD: begin
                    cmd_q   <= blk_req_i.wdata;
                    notif_q <= 1'b1;
                end
                REG_ID: begin
                    err_q <= 1'b1;              // Data dropped, flag the bad write
                end
                REG_SCRATCH: begin
                    scratch_q <= blk_req_i.wdata;
                end
                REG_STATUS: begin
                    // Write one to clear
                    if (blk_req_i.wdata[1]) begin
                        err_q <= 1'b0;
                    end
                    if (blk_req_i.wdata[0]) begin
                        notif_q <= 1'b0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Response one cycle after the select
    always_ff @(posedge clk) begin
        if (reset_i) begin
            blk_rsp_o.valid <= 1'b0;
        end else begin
            blk_rsp_o.valid <= sel_i;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_i) begin
            blk_rsp_o.rdata <= blk_req_i.write ? '0 : rd_mux;   // Writes answer with zero
        end
    end

    assign err_irq_o   = err_q;
    assign notif_irq_o = notif_q;

endmodule

`default_nettype wire

//--- periph_addr_decoder.sv
// Address decoder turning each request into a registered responder select or error token
`timescale 1ns/1ps
`default_nettype none

module periph_addr_decoder (
    input  logic                                  clk,
    input  logic                                  reset_i,
    input  periph_fabric_pkg::bus_req_t           req_i,
    input  logic [periph_fabric_pkg::NUM_RESP-1:0] resp_disable_i,
    output periph_fabric_pkg::blk_req_t           blk_req_o,
    output logic [periph_fabric_pkg::NUM_RESP-1:0] blk_sel_o,
    output logic                                  dec_err_o,
    output logic                                  access_blocked_o
);

    import periph_fabric_pkg::*;

    logic [NUM_RESP-1:0] sel_onehot;
    logic                mapped;
    logic                disabled;

    // ========================================================================
    // Window decode
    // ========================================================================
    always_comb begin
        for (int i = 0; i < NUM_RESP; i++) begin
            sel_onehot[i] = (req_i.addr.fields.sel == SEL_W'(i));
        end
        mapped   = |sel_onehot;                     // Zero for selects past the last block
        disabled = |(sel_onehot & resp_disable_i);
    end

    // Control stage
    always_ff @(posedge clk) begin
        if (reset_i) begin
            blk_sel_o        <= '0;
            dec_err_o        <= 1'b0;
            access_blocked_o <= 1'b0;
        end else begin
            blk_sel_o        <= (req_i.valid && !disabled) ? sel_onehot : '0;
            dec_err_o        <= req_i.valid && (!mapped || disabled);
            access_blocked_o <= req_i.valid && disabled;   // Locked responder hit
        end
    end

    // Request payload, only meaningful while a select bit is high
    always_ff @(posedge clk) begin
        if (req_i.valid) begin
            blk_req_o.write   <= req_i.write;
            blk_req_o.reg_idx <= req_i.addr.fields.reg_idx;
            blk_req_o.wdata   <= req_i.wdata;
        end
    end

endmodule

`default_nettype wire

//--- periph_fabric_pkg.sv
// Shared widths, register map and bus types of the peripheral fabric
`default_nettype none

package periph_fabric_pkg;

    // ========================================================================
    // Widths and counts
    // ========================================================================
    localparam int DATA_W      = 32;
    localparam int NUM_RESP    = 4;                          // Peripheral register blocks
    localparam int SEL_W       = 3;                          // Selects NUM_RESP..7 unmapped
    localparam int REG_IDX_W   = 2;
    localparam int BYTE_OFFS_W = 2;
    localparam int ADDR_W      = SEL_W + REG_IDX_W + BYTE_OFFS_W;
    localparam int NUM_INTR    = 2 * NUM_RESP + 1;          // Bit 0 reserved

    // Identity value of block 0, later blocks count up from here
    localparam logic [DATA_W-1:0] INST_ID_BASE = 32'h0000_00A0;

    // ========================================================================
    // Register map inside one block
    // ========================================================================
    localparam logic [REG_IDX_W-1:0] REG_CMD     = 2'd0;
    localparam logic [REG_IDX_W-1:0] REG_ID      = 2'd1;
    localparam logic [REG_IDX_W-1:0] REG_SCRATCH = 2'd2;
    localparam logic [REG_IDX_W-1:0] REG_STATUS  = 2'd3;

    // ========================================================================
    // Bus types
    // ========================================================================
    typedef struct packed {
        logic [SEL_W-1:0]       sel;       // Responder window
        logic [REG_IDX_W-1:0]   reg_idx;
        logic [BYTE_OFFS_W-1:0] byte_offs; // Ignored, word access only
    } bus_addr_fields_t;

    // Same address word, seen raw by the initiator or split by the decoder
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        bus_addr_fields_t  fields;
    } bus_addr_u;

    typedef struct packed {
        logic              valid;   // Single-cycle strobe
        logic              write;
        bus_addr_u         addr;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic              valid;
        logic              err;
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

    // Decoder to block, select travels on its own vector
    typedef struct packed {
        logic                 write;
        logic [REG_IDX_W-1:0] reg_idx;
        logic [DATA_W-1:0]    wdata;
    } blk_req_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] rdata;
    } blk_rsp_t;

endpackage

`default_nettype wire
